// File: logic/rx_pkg.sv
package rx_pkg;

	//////////////////////////////
	// lane word geometry
	//////////////////////////////
	localparam int sample_w   = 16;			// one front-end data word
	localparam int line_words = 16;			// words packed into one dram line
	localparam int line_w     = sample_w * line_words;	// 256 bit line
	localparam int ts_w       = 16;			// free-running timestamp width

	typedef logic [ts_w-1:0] ts_t;			// cycle count since reset, wraps

	//////////////////////////////
	// lane words
	//////////////////////////////

	// raw word as it arrives from a front-end board, 20 bits
	typedef struct packed {
		logic [sample_w-1:0] data;		// decoded word
		logic [1:0]          datak;		// control word flag, one per byte
		logic [1:0]          syncstatus;	// word aligner lock, one per byte
	} rx_lane_t;

	// qualified word after lane_ingress
	typedef struct packed {
		logic                valid;		// synced data word present
		logic [sample_w-1:0] data;		// payload
	} sample_t;

endpackage

// File: logic/dram_pkg.sv
package dram_pkg;

	//////////////////////////////
	// avalon write port
	//////////////////////////////
	localparam int avl_addr_w = 25;		// word address, one 256 bit beat each
	localparam int avl_data_w = 256;	// one full line per beat

	// channel index sits in the top 3 bits, the line count below
	localparam int line_idx_w = 22;		// avl_addr_w less the channel field

	//////////////////////////////
	// write command
	//////////////////////////////

	// single beat write, held while waitrequest_n is low
	typedef struct packed {
		logic                  write;		// request level
		logic [avl_addr_w-1:0] address;		// {channel, line count}
		logic [avl_data_w-1:0] writedata;	// registered line
	} avl_wr_t;

	//////////////////////////////
	// write controller FSM
	//////////////////////////////
	typedef enum logic [1:0] {
		st_idle,	// wait for any ready buffer
		st_load,	// take the line, latch data and address
		st_write	// hold write until waitrequest_n
	} wr_state_e;

endpackage

// File: logic/lane_ingress.sv
`timescale 1ns/1ps

module lane_ingress #(
	parameter int num_lanes = 8,
	parameter logic [rx_pkg::sample_w-1:0] trig_threshold = 16'h0800
) (
	input  logic             avalon_clk,
	input  logic             rst_n,
	input  rx_pkg::rx_lane_t lanes [num_lanes],	// raw words, one per board
	output rx_pkg::sample_t  samples [num_lanes],	// qualified, one cycle late
	output logic             trigger_status,		// sticky first crossing
	output rx_pkg::ts_t      trigger_time_stamp		// time of that crossing
);

	rx_pkg::ts_t          ts_cnt;		// free-running stamp
	logic [num_lanes-1:0] lane_ok;		// word is synced data
	logic [num_lanes-1:0] lane_cross;	// data word above threshold

	//////////////////////////////
	// timestamp
	//////////////////////////////
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			ts_cnt <= '0;			// 0 in the first cycle out of reset
		end else begin
			ts_cnt <= ts_cnt + 1'b1;	// wraps at 16 bits
		end
	end

	//////////////////////////////
	// qualification
	//////////////////////////////
	always_comb begin
		for (int i = 0; i < num_lanes; i++) begin
			// both bytes locked and neither one a control character
			lane_ok[i]    = (&lanes[i].syncstatus) && !(|lanes[i].datak);
			lane_cross[i] = lane_ok[i] && (lanes[i].data > trig_threshold);	// strict
		end
	end

	// sample register one cycle behind the lane input
	always_ff @(posedge avalon_clk) begin
		for (int i = 0; i < num_lanes; i++) begin
			samples[i].data <= lanes[i].data;
			if (!rst_n) begin
				samples[i].valid <= 1'b0;
			end else begin
				samples[i].valid <= lane_ok[i];	// drop k-chars and unsynced words
			end
		end
	end

	//////////////////////////////
	// trigger
	//////////////////////////////

	// all lanes share one stamp, so a tie still gives a single time
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			trigger_status     <= 1'b0;
			trigger_time_stamp <= '0;
		end else if (!trigger_status && (|lane_cross)) begin
			trigger_status     <= 1'b1;		// holds until reset
			trigger_time_stamp <= ts_cnt;		// stamp of the crossing word
		end
	end

endmodule

// File: logic/channel_line_buffer.sv
`timescale 1ns/1ps

module channel_line_buffer (
	input  logic                      avalon_clk,
	input  logic                      rst_n,
	input  rx_pkg::sample_t           sample,		// qualified lane word
	input  logic                      line_take,	// pulse from write controller
	output logic                      line_ready,	// oldest slot holds a line
	output logic [rx_pkg::line_w-1:0] line_data,	// oldest full slot
	output logic                      overflow		// sticky, a word was lost
);

	localparam int cnt_w = $clog2(rx_pkg::line_words);

	logic [cnt_w-1:0]          word_cnt;	// next word position in fill line
	logic [rx_pkg::line_w-1:0] fill_q;		// line being packed
	logic [rx_pkg::line_w-1:0] fill_word;	// fill line with this cycle's word
	logic                      fill_done;	// fill line complete, no slot yet
	logic [rx_pkg::line_w-1:0] slot_q [2];	// two lines in flight
	logic [1:0]                slot_full;
	logic                      rd_ptr;		// oldest slot
	logic                      wr_ptr;		// next free slot
	logic                      slot_free;
	logic                      accept;		// word goes into fill line
	logic                      complete;	// sixteenth word this cycle
	logic                      move;		// parked fill line into a slot
	logic                      slot_wr;

	assign slot_free = ~&slot_full;
	assign wr_ptr    = slot_full[rd_ptr] ? ~rd_ptr : rd_ptr;
	assign move      = fill_done && slot_free;
	assign accept    = sample.valid && (!fill_done || slot_free);
	assign complete  = accept && (word_cnt == cnt_w'(rx_pkg::line_words - 1));
	assign slot_wr   = move || (complete && slot_free);

	// word 0 lands in bits 15:0, later words stack upward
	always_comb begin
		fill_word = fill_q;
		fill_word[word_cnt*rx_pkg::sample_w +: rx_pkg::sample_w] = sample.data;
	end

	//////////////////////////////
	// line storage
	//////////////////////////////
	always_ff @(posedge avalon_clk) begin
		if (accept) begin
			fill_q <= fill_word;
		end
		if (slot_wr) begin
			// a parked line goes first, otherwise the line just finished
			slot_q[wr_ptr] <= move ? fill_q : fill_word;
		end
	end

	//////////////////////////////
	// occupancy
	//////////////////////////////
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			word_cnt  <= '0;
			fill_done <= 1'b0;
			slot_full <= 2'b00;
			rd_ptr    <= 1'b0;
			overflow  <= 1'b0;
		end else begin
			if (accept) begin
				word_cnt <= word_cnt + 1'b1;	// wraps to 0 after word 15
			end
			if (complete && !slot_free) begin
				fill_done <= 1'b1;		// both slots busy, park it
			end else if (move) begin
				fill_done <= 1'b0;
			end
			if (line_take && slot_full[rd_ptr]) begin
				slot_full[rd_ptr] <= 1'b0;	// free in the cycle after the pulse
				rd_ptr            <= ~rd_ptr;
			end
			if (slot_wr) begin
				slot_full[wr_ptr] <= 1'b1;	// never the slot being taken
			end
			if (sample.valid && fill_done && !slot_free) begin
				overflow <= 1'b1;		// slots and fill line all full
			end
		end
	end

	assign line_ready = slot_full[rd_ptr];
	assign line_data  = slot_q[rd_ptr];

endmodule

// File: logic/dram_write_ctrl.sv
`timescale 1ns/1ps

module dram_write_ctrl #(
	parameter int num_lanes = 8
) (
	input  logic                      avalon_clk,
	input  logic                      rst_n,
	input  logic [num_lanes-1:0]      line_ready,		// one level per buffer
	input  logic [rx_pkg::line_w-1:0] line_data [num_lanes],
	output logic [num_lanes-1:0]      line_take,		// one cycle pulse
	input  logic                      avl_waitrequest_n,
	output dram_pkg::avl_wr_t         avl_wr
);

	localparam int ch_w = dram_pkg::avl_addr_w - dram_pkg::line_idx_w;	// 3

	dram_pkg::wr_state_e              state;
	logic [ch_w-1:0]                  last_q;		// channel served last
	logic [ch_w-1:0]                  sel_q;		// channel being written
	logic [ch_w-1:0]                  pick;		// round-robin winner
	logic                             pick_valid;
	logic [dram_pkg::line_idx_w-1:0]  line_cnt [num_lanes];	// lines written per channel
	logic                             wr_q;
	logic [dram_pkg::avl_addr_w-1:0]  addr_q;
	logic [dram_pkg::avl_data_w-1:0]  data_q;		// registered select mux

	//////////////////////////////
	// round-robin pick
	//////////////////////////////

	// search starts at the channel after the last one served
	always_comb begin
		int idx;
		pick_valid = 1'b0;
		pick       = last_q;
		for (int k = 1; k <= num_lanes; k++) begin
			idx = (int'(last_q) + k) % num_lanes;
			if (!pick_valid && line_ready[idx]) begin
				pick_valid = 1'b1;
				pick       = ch_w'(idx);
			end
		end
	end

	// take pulse goes only to the selected buffer
	always_comb begin
		line_take = '0;
		if (state == dram_pkg::st_load) begin
			line_take[sel_q] = 1'b1;
		end
	end

	//////////////////////////////
	// write FSM
	//////////////////////////////
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			state  <= dram_pkg::st_idle;
			last_q <= ch_w'(num_lanes - 1);	// channel 0 goes first
			sel_q  <= '0;
			wr_q   <= 1'b0;
			for (int i = 0; i < num_lanes; i++) begin
				line_cnt[i] <= '0;
			end
		end else begin
			case (state)
				dram_pkg::st_idle: begin
					if (pick_valid) begin
						sel_q <= pick;
						state <= dram_pkg::st_load;
					end
				end
				dram_pkg::st_load: begin
					wr_q   <= 1'b1;		// data and address latch this edge too
					last_q <= sel_q;
					state  <= dram_pkg::st_write;
				end
				dram_pkg::st_write: begin
					if (avl_waitrequest_n) begin	// beat accepted
						wr_q            <= 1'b0;
						line_cnt[sel_q] <= line_cnt[sel_q] + 1'b1;
						state           <= dram_pkg::st_idle;
					end
				end
				default: begin
					state <= dram_pkg::st_idle;
				end
			endcase
		end
	end

	//////////////////////////////
	// address and data
	//////////////////////////////

	// loaded once per line, stable through any number of stall cycles
	always_ff @(posedge avalon_clk) begin
		if (state == dram_pkg::st_load) begin
			data_q <= line_data[sel_q];
			addr_q <= {sel_q, line_cnt[sel_q]};	// channel region, then line
		end
	end

	assign avl_wr = '{write: wr_q, address: addr_q, writedata: data_q};

endmodule

// File: logic/capture_top.sv
`timescale 1ns/1ps

module capture_top #(
	parameter int num_lanes = 8,		// channel field is 3 bits, so 8 at most
	parameter logic [rx_pkg::sample_w-1:0] trig_threshold = 16'h0800
) (
	input  logic                 avalon_clk,
	input  logic                 rst_n,
	input  rx_pkg::rx_lane_t     lanes [num_lanes],	// one per front-end board
	input  logic                 avl_waitrequest_n,
	output dram_pkg::avl_wr_t    avl_wr,			// single beat writes
	output logic                 trigger_status,
	output rx_pkg::ts_t          trigger_time_stamp,
	output logic [num_lanes-1:0] overflow		// per lane, sticky
);

	rx_pkg::sample_t           samples [num_lanes];	// ingress to buffers
	logic [num_lanes-1:0]      line_ready;		// buffers to controller
	logic [num_lanes-1:0]      line_take;		// controller to buffers
	logic [rx_pkg::line_w-1:0] line_data [num_lanes];

	//////////////////////////////
	// ingress and trigger
	//////////////////////////////
	lane_ingress #(
		.num_lanes      (num_lanes),
		.trig_threshold (trig_threshold)
	) lane_ingress_inst (
		.avalon_clk         (avalon_clk),
		.rst_n              (rst_n),
		.lanes              (lanes),
		.samples            (samples),
		.trigger_status     (trigger_status),
		.trigger_time_stamp (trigger_time_stamp)
	);

	//////////////////////////////
	// per lane line buffers
	//////////////////////////////
	for (genvar i = 0; i < num_lanes; i++) begin : g_buf
		channel_line_buffer channel_line_buffer_inst (
			.avalon_clk (avalon_clk),
			.rst_n      (rst_n),
			.sample     (samples[i]),
			.line_take  (line_take[i]),
			.line_ready (line_ready[i]),
			.line_data  (line_data[i]),
			.overflow   (overflow[i])
		);
	end

	//////////////////////////////
	// dram writer
	//////////////////////////////
	dram_write_ctrl #(
		.num_lanes (num_lanes)
	) dram_write_ctrl_inst (
		.avalon_clk        (avalon_clk),
		.rst_n             (rst_n),
		.line_ready        (line_ready),
		.line_data         (line_data),
		.line_take         (line_take),
		.avl_waitrequest_n (avl_waitrequest_n),
		.avl_wr            (avl_wr)
	);

endmodule

// File: include/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////
// lane drive
//////////////////////////////

// advance one clock then set this cycle's inputs 1 ns after the edge
task automatic next_cycle();
	@(posedge avalon_clk);
	#1;
	for (int i = 0; i < num_lanes; i++) begin
		lanes[i] = '{data: 16'h0000, datak: 2'b00, syncstatus: 2'b00};	// no lock
	end
	case (stall_mode)
		0: avl_waitrequest_n = 1'b1;
		1: avl_waitrequest_n = ($urandom % 2) == 0;	// coin flip stalls
		default: avl_waitrequest_n = 1'b0;		// memory held busy
	endcase
endtask

// raw word on one lane, nothing recorded
task automatic drive_word(input int lane, input logic [1:0] k, input logic [1:0] sync,
		input logic [15:0] d);
	lanes[lane] = '{data: d, datak: k, syncstatus: sync};
endtask

// qualified word that has to reach dram in order
task automatic send_data(input int lane, input logic [15:0] d);
	drive_word(lane, 2'b00, 2'b11, d);
	shadow_q[lane].push_back(d);
	words_sent[lane]++;
	if (words_sent[lane] % rx_pkg::line_words == 0) begin
		lines_sent[lane]++;			// one more full line owed
	end
endtask

// word the ingress must discard
task automatic send_junk(input int lane, input int kind, input logic [15:0] d);
	case (kind)
		0: drive_word(lane, 2'b01, 2'b11, d);	// low byte k-char
		1: drive_word(lane, 2'b10, 2'b11, d);	// high byte k-char
		2: drive_word(lane, 2'b00, 2'b10, d);	// low byte out of lock
		default: drive_word(lane, 2'b00, 2'b01, d);	// high byte out of lock
	endcase
endtask

// top every lane up to a whole number of lines
task automatic pad_lanes();
	for (int w = 0; w < rx_pkg::line_words; w++) begin
		next_cycle();
		for (int i = 0; i < num_lanes; i++) begin
			if (words_sent[i] % rx_pkg::line_words != 0) begin
				send_data(i, 16'($urandom) & 16'h07ff);
			end
		end
	end
endtask

//////////////////////////////
// expected lines
//////////////////////////////

// next 16 words of a lane, first word in bits 15:0
function automatic logic [rx_pkg::line_w-1:0] expected_line(input int lane);
	logic [rx_pkg::line_w-1:0] line;
	line = '0;
	for (int w = 0; w < rx_pkg::line_words; w++) begin
		line[w*rx_pkg::sample_w +: rx_pkg::sample_w] = shadow_q[lane].pop_front();
	end
	return line;
endfunction

function automatic bit all_written();
	for (int i = 0; i < num_lanes; i++) begin
		if (wr_count[i] != lines_sent[i]) begin
			return 1'b0;
		end
	end
	return 1'b1;
endfunction

`endif

// File: tb/tb_capture_top.sv
`timescale 1ns/1ps

module tb_capture_top;

	localparam int num_lanes                 = 8;
	localparam logic [15:0] trig_threshold  = 16'h0800;
	localparam int data_cycles               = 1200;	// random traffic phase
	localparam int trig_cycles               = 40;
	localparam int ovf_cycles                = 80;
	localparam int drain_limit               = 1000;	// cycles allowed per drain
	localparam int stim_cycles = data_cycles + rx_pkg::line_words + trig_cycles + ovf_cycles;
	localparam int watchdog_cycles           = 2 * stim_cycles + 2000;
	localparam int ovf_lane                  = 5;

	logic                 avalon_clk;
	logic                 rst_n;
	rx_pkg::rx_lane_t     lanes [num_lanes];
	logic                 avl_waitrequest_n;
	dram_pkg::avl_wr_t    avl_wr;
	logic                 trigger_status;
	rx_pkg::ts_t          trigger_time_stamp;
	logic [num_lanes-1:0] overflow;

	int                   stall_mode;		// 0 none, 1 random, 2 held low
	int unsigned          edge_cnt = 0;		// edges since reset release
	logic [15:0]          shadow_q [num_lanes][$];	// qualified words not yet written
	int                   words_sent [num_lanes];
	int                   lines_sent [num_lanes];
	int                   wr_count [num_lanes];	// completed writes per lane
	logic                 hold_valid = 1'b0;	// last cycle was a stalled write
	logic [24:0]          hold_addr;
	logic [255:0]         hold_data;

	initial avalon_clk = 1'b0;
	always #5 avalon_clk = ~avalon_clk;

	// stamp a word will get is the edge count when it is driven
	always @(posedge avalon_clk) begin
		if (rst_n) begin
			edge_cnt <= edge_cnt + 1;
		end
	end

	capture_top #(
		.num_lanes      (num_lanes),
		.trig_threshold (trig_threshold)
	) capture_top_inst (
		.avalon_clk         (avalon_clk),
		.rst_n              (rst_n),
		.lanes              (lanes),
		.avl_waitrequest_n  (avl_waitrequest_n),
		.avl_wr             (avl_wr),
		.trigger_status     (trigger_status),
		.trigger_time_stamp (trigger_time_stamp),
		.overflow           (overflow)
	);

	//////////////////////////////
	// failure reporting
	//////////////////////////////
	task automatic stop_failed();
		$display("RESULT: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [255:0] exp,
			input logic [255:0] act);
		$display("CHECK FAILED at %0t ns: %s expected %0h actual %0h", $time, name, exp, act);
		stop_failed();
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		stop_failed();
	endtask

	task automatic check_value(input string name, input logic [255:0] exp,
			input logic [255:0] act);
		assert (exp == act) else report_mismatch(name, exp, act);
	endtask

	`include "tb_tasks.svh"

	// run until every owed line is in memory
	task automatic drain();
		int n;
		n = 0;
		while (!all_written() && n < drain_limit) begin
			next_cycle();
			n++;
		end
		assert (all_written()) else report_error("lines still unwritten after the drain limit");
	endtask

	//////////////////////////////
	// concurrent checks
	//////////////////////////////
	a_rst_write: assert property (@(posedge avalon_clk) !rst_n |=> !avl_wr.write)
		else report_mismatch("avl_wr.write", 256'(0), 256'($sampled(avl_wr.write)));
	a_rst_trig: assert property (@(posedge avalon_clk) !rst_n |=> !trigger_status)
		else report_mismatch("trigger_status", 256'(0), 256'($sampled(trigger_status)));
	a_rst_ovf: assert property (@(posedge avalon_clk) !rst_n |=> overflow == '0)
		else report_mismatch("overflow", 256'(0), 256'($sampled(overflow)));
	a_trig_sticky: assert property (@(posedge avalon_clk) disable iff (!rst_n)
		trigger_status |=> trigger_status)
		else report_mismatch("trigger_status", 256'(1), 256'($sampled(trigger_status)));
	a_write_held: assert property (@(posedge avalon_clk) disable iff (!rst_n)
		(avl_wr.write && !avl_waitrequest_n) |=> avl_wr.write)
		else report_mismatch("avl_wr.write", 256'(1), 256'($sampled(avl_wr.write)));

	//////////////////////////////
	// memory model
	//////////////////////////////

	// a beat seen at mid-cycle completes at the next rising edge
	always @(negedge avalon_clk) begin
		int lane;
		logic [24:0] exp_addr;
		logic [255:0] exp_line;
		if (rst_n) begin
			if (hold_valid) begin
				assert (avl_wr.address == hold_addr)
					else report_mismatch("avl_wr.address", 256'(hold_addr), 256'(avl_wr.address));
				assert (avl_wr.writedata == hold_data)
					else report_mismatch("avl_wr.writedata", hold_data, avl_wr.writedata);
			end
			hold_valid = avl_wr.write && !avl_waitrequest_n;
			hold_addr  = avl_wr.address;
			hold_data  = avl_wr.writedata;
			if (avl_wr.write && avl_waitrequest_n) begin
				lane     = int'(avl_wr.address[24:22]);		// channel region
				exp_addr = {3'(lane), 22'(wr_count[lane])};
				assert (shadow_q[lane].size() >= rx_pkg::line_words)
					else report_error("write for a lane with no complete line sent");
				assert (avl_wr.address == exp_addr)
					else report_mismatch("avl_wr.address", 256'(exp_addr), 256'(avl_wr.address));
				exp_line = expected_line(lane);
				assert (avl_wr.writedata == exp_line)
					else report_mismatch("avl_wr.writedata", exp_line, avl_wr.writedata);
				wr_count[lane]++;
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge avalon_clk);
		report_error("watchdog expired before the test sequence finished");
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial begin
		int unsigned r;
		logic [15:0] d;
		logic [15:0] trig_ts;
		int n;
		void'($urandom(32'hda7));
		rst_n             = 1'b0;
		avl_waitrequest_n = 1'b1;
		stall_mode        = 0;
		trig_ts           = '0;
		for (int i = 0; i < num_lanes; i++) begin
			lanes[i] = '{data: 16'h0000, datak: 2'b00, syncstatus: 2'b00};
		end
		repeat (2) @(posedge avalon_clk);
		#1;
		rst_n = 1'b1;
		check_value("avl_wr.write", 256'(0), 256'(avl_wr.write));
		check_value("trigger_status", 256'(0), 256'(trigger_status));
		check_value("overflow", 256'(0), 256'(overflow));

		// mixed data and discard words on all lanes with random stalls
		stall_mode = 1;
		repeat (data_cycles) begin
			next_cycle();
			for (int i = 0; i < num_lanes; i++) begin
				r = $urandom % 8;
				d = 16'($urandom);		// discard words may exceed the threshold
				if (r < 2) begin
					send_data(i, d & 16'h07ff);	// stays under the threshold
				end else if (r < 6) begin
					send_junk(i, int'(r) - 2, d);
				end
			end
		end
		pad_lanes();
		stall_mode = 0;
		drain();
		check_value("trigger_status", 256'(0), 256'(trigger_status));
		check_value("overflow", 256'(0), 256'(overflow));

		// threshold equal at k 2, crossing at k 6, larger crossing at k 10
		for (int k = 0; k < rx_pkg::line_words; k++) begin
			next_cycle();
			if (k <= 6) begin
				check_value("trigger_status", 256'(0), 256'(trigger_status));
			end else if (k == 7) begin
				check_value("trigger_status", 256'(1), 256'(trigger_status));
				check_value("trigger_time_stamp", 256'(trig_ts), 256'(trigger_time_stamp));
			end
			case (k)
				2: d = 16'h0800;
				6: d = 16'h0801;
				10: d = 16'hffff;
				default: d = 16'($urandom) & 16'h07ff;
			endcase
			if (k == 6) begin
				trig_ts = 16'(edge_cnt);	// stamp the crossing word will carry
			end
			send_data(0, d);
			if (k < 6) begin
				send_junk(3, 0, 16'hffff);	// k-char above threshold
			end
		end
		repeat (3) next_cycle();
		check_value("trigger_status", 256'(1), 256'(trigger_status));
		check_value("trigger_time_stamp", 256'(trig_ts), 256'(trigger_time_stamp));
		drain();

		// memory busy so one line sits in the controller and three more back up
		stall_mode = 2;
		for (int k = 0; k < 4 * rx_pkg::line_words; k++) begin
			next_cycle();
			send_data(ovf_lane, 16'($urandom) & 16'h07ff);
		end
		repeat (4) next_cycle();
		check_value("overflow", 256'(0), 256'(overflow));
		next_cycle();
		drive_word(ovf_lane, 2'b00, 2'b11, 16'h0123);	// nowhere to go
		n = 0;
		while (!overflow[ovf_lane] && n < 8) begin
			next_cycle();
			n++;
		end
		check_value("overflow", 256'(1 << ovf_lane), 256'(overflow));
		stall_mode = 0;
		drain();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: all.f
+incdir+include
logic/rx_pkg.sv
logic/dram_pkg.sv
logic/lane_ingress.sv
logic/channel_line_buffer.sv
logic/dram_write_ctrl.sv
logic/capture_top.sv
tb/tb_capture_top.sv

// File: Makefile
# Verilator build for the capture project

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_capture_top
RTL_TOP   ?= capture_top
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -j $(JOBS) \
		-f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
